/* source/aluPkg.sv */
package aluPkg;

    localparam int DataWidth = 32;
    localparam int FuncWidth = 6;
    localparam int SqrtSteps = 16;

    // Counter widths and load values for the iterative units
    localparam int DivCountWidth = $clog2(DataWidth) + 1;
    localparam int SqrtCountWidth = $clog2(SqrtSteps);
    localparam logic [DivCountWidth-1:0] DivSteps = DivCountWidth'(DataWidth);
    localparam logic [SqrtCountWidth-1:0] SqrtLast = SqrtCountWidth'(SqrtSteps - 1);

    typedef enum logic [FuncWidth-1:0] {
        IntAdd          = 6'b000000,
        IntSub          = 6'b000001,
        IntMul          = 6'b000010,
        IntSqrt         = 6'b000011,
        IntDiv          = 6'b000100,
        IntMod          = 6'b000101,
        ShiftLeftArith  = 6'b000110,
        ShiftRightArith = 6'b000111,
        CmpEq           = 6'b001000,
        CmpNe           = 6'b001001,
        CmpGt           = 6'b001010,
        CmpGe           = 6'b001011,
        LogNot          = 6'b010000,
        LogAnd          = 6'b010001,
        LogOr           = 6'b010010,
        LogXor          = 6'b010011,
        LogXnor         = 6'b010100,
        ShiftLeftLogic  = 6'b010110,
        ShiftRightLogic = 6'b010111
    } funcCodeE;

    typedef enum logic [1:0] {
        UnitSimple = 2'd0,
        UnitDiv    = 2'd1,
        UnitSqrt   = 2'd2
    } unitClassE;

    typedef enum logic {
        DivIdle,
        DivRun
    } divStateE;

    typedef enum logic {
        SqrtIdle,
        SqrtRun
    } sqrtStateE;

endpackage

/* source/aluLaunchIf.sv */
`timescale 1ns/1ps

interface aluLaunchIf;

    logic goSimple; // One-cycle pulses, at most one high
    logic goDiv;
    logic goSqrt;
    aluPkg::funcCodeE func;
    logic [aluPkg::DataWidth-1:0] opA;
    logic [aluPkg::DataWidth-1:0] opB;

    modport dispatch (output goSimple, goDiv, goSqrt, func, opA, opB);

    // Each unit only looks at its own go
    modport unit (input goSimple, goDiv, goSqrt, func, opA, opB);

    modport commit (input goSimple, goDiv, goSqrt);

endinterface

/* source/aluDispatch.sv */
`timescale 1ns/1ps

module aluDispatch (
    input  logic                           Clock,
    input  logic                           i_rstN,
    input  logic                           i_start,
    input  logic [aluPkg::FuncWidth-1:0]   i_func,
    input  logic [aluPkg::DataWidth-1:0]   i_opA,
    input  logic [aluPkg::DataWidth-1:0]   i_opB,
    input  logic                           i_busy,
    aluLaunchIf.dispatch                   launch
);

    aluPkg::unitClassE unitSel;
    logic accept;

    assign accept = i_start && !i_busy; // Starts while busy are dropped

    // Operands go straight through, units sample them on their go
    assign launch.func = aluPkg::funcCodeE'(i_func);
    assign launch.opA = i_opA;
    assign launch.opB = i_opB;

    always_comb begin
        case (launch.func)
            aluPkg::IntDiv,
            aluPkg::IntMod:  unitSel = aluPkg::UnitDiv;
            aluPkg::IntSqrt: unitSel = aluPkg::UnitSqrt;
            default:         unitSel = aluPkg::UnitSimple; // Unknown codes too
        endcase
    end

    assign launch.goSimple = accept && (unitSel == aluPkg::UnitSimple);
    assign launch.goDiv = accept && (unitSel == aluPkg::UnitDiv);
    assign launch.goSqrt = accept && (unitSel == aluPkg::UnitSqrt);

    // Busy must come back from commit right after any go
    goRaisesBusy: assert property (@(posedge Clock) disable iff (!i_rstN)
        (launch.goSimple || launch.goDiv || launch.goSqrt) |=> i_busy);

endmodule

/* source/aluSimpleOps.sv */
`timescale 1ns/1ps

module aluSimpleOps (
    input  logic                           Clock,
    input  logic                           i_rstN,
    aluLaunchIf.unit                       launch,
    output logic                           o_valid,
    output logic [aluPkg::DataWidth-1:0]   o_result
);

    logic [aluPkg::DataWidth-1:0] value;
    logic [4:0] shamt;

    assign shamt = launch.opB[4:0];

    always_comb begin
        case (launch.func)
            aluPkg::IntAdd:          value = launch.opA + launch.opB;
            aluPkg::IntSub:          value = launch.opA - launch.opB;
            aluPkg::IntMul:          value = launch.opA * launch.opB; // Low half only
            aluPkg::ShiftLeftArith:  value = launch.opA << shamt;
            aluPkg::ShiftRightArith: value = $signed(launch.opA) >>> shamt;
            aluPkg::ShiftLeftLogic:  value = launch.opA << shamt;
            aluPkg::ShiftRightLogic: value = launch.opA >> shamt;
            aluPkg::CmpEq:
                value = {{(aluPkg::DataWidth - 1){1'b0}}, launch.opA == launch.opB};
            aluPkg::CmpNe:
                value = {{(aluPkg::DataWidth - 1){1'b0}}, launch.opA != launch.opB};
            aluPkg::CmpGt:
                value = {{(aluPkg::DataWidth - 1){1'b0}},
                         $signed(launch.opA) > $signed(launch.opB)};
            aluPkg::CmpGe:
                value = {{(aluPkg::DataWidth - 1){1'b0}},
                         $signed(launch.opA) >= $signed(launch.opB)};
            aluPkg::LogNot:          value = ~launch.opA;
            aluPkg::LogAnd:          value = launch.opA & launch.opB;
            aluPkg::LogOr:           value = launch.opA | launch.opB;
            aluPkg::LogXor:          value = launch.opA ^ launch.opB;
            aluPkg::LogXnor:         value = launch.opA ~^ launch.opB;
            default:                 value = '0;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (!i_rstN) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= launch.goSimple;
        end
    end

    always_ff @(posedge Clock) begin
        if (launch.goSimple) begin
            o_result <= value;
        end
    end

endmodule

/* source/aluDivider.sv */
`timescale 1ns/1ps

module aluDivider (
    input  logic                           Clock,
    input  logic                           i_rstN,
    aluLaunchIf.unit                       launch,
    output logic                           o_valid,
    output logic [aluPkg::DataWidth-1:0]   o_result
);

    aluPkg::divStateE state;
    logic [aluPkg::DivCountWidth-1:0] bitCnt;
    logic [aluPkg::DataWidth-1:0] divisor;
    logic [aluPkg::DataWidth-1:0] quotient; // Holds the dividend while shifting out
    logic [aluPkg::DataWidth-1:0] remainder;
    logic negQuot;
    logic negRem;
    logic isMod;
    logic signA;
    logic signB;
    logic [aluPkg::DataWidth:0] shifted;
    logic [aluPkg::DataWidth:0] diff;

    assign signA = launch.opA[aluPkg::DataWidth-1];
    assign signB = launch.opB[aluPkg::DataWidth-1];

    assign shifted = {remainder, quotient[aluPkg::DataWidth-1]};
    assign diff = shifted - {1'b0, divisor};

    always_ff @(posedge Clock) begin
        if (!i_rstN) begin
            state <= aluPkg::DivIdle;
            bitCnt <= '0;
            o_valid <= 1'b0;
        end else begin
            o_valid <= 1'b0;
            case (state)
                aluPkg::DivIdle: begin
                    if (launch.goDiv) begin
                        state <= aluPkg::DivRun;
                        bitCnt <= aluPkg::DivSteps;
                    end
                end
                aluPkg::DivRun: begin
                    if (bitCnt == '0) begin // Sign-fix cycle
                        state <= aluPkg::DivIdle;
                        o_valid <= 1'b1;
                    end else begin
                        bitCnt <= bitCnt - 1'b1;
                    end
                end
                default: state <= aluPkg::DivIdle;
            endcase
        end
    end

    always_ff @(posedge Clock) begin
        if (launch.goDiv) begin
            quotient <= signA ? -launch.opA : launch.opA;
            divisor <= signB ? -launch.opB : launch.opB;
            remainder <= '0;
            negQuot <= (signA ^ signB) && (launch.opB != '0); // Div by zero stays all ones
            negRem <= signA;
            isMod <= (launch.func == aluPkg::IntMod);
        end else if (state == aluPkg::DivRun && bitCnt != '0) begin
            if (!diff[aluPkg::DataWidth]) begin
                remainder <= diff[aluPkg::DataWidth-1:0];
                quotient <= {quotient[aluPkg::DataWidth-2:0], 1'b1};
            end else begin
                remainder <= shifted[aluPkg::DataWidth-1:0];
                quotient <= {quotient[aluPkg::DataWidth-2:0], 1'b0};
            end
        end else if (state == aluPkg::DivRun) begin
            if (isMod) begin
                o_result <= negRem ? -remainder : remainder;
            end else begin
                o_result <= negQuot ? -quotient : quotient;
            end
        end
    end

    noGoWhileRun: assert property (@(posedge Clock) disable iff (!i_rstN)
        launch.goDiv |-> state == aluPkg::DivIdle);

endmodule

/* source/aluIntSqrt.sv */
`timescale 1ns/1ps

module aluIntSqrt (
    input  logic                           Clock,
    input  logic                           i_rstN,
    aluLaunchIf.unit                       launch,
    output logic                           o_valid,
    output logic [aluPkg::DataWidth-1:0]   o_result
);

    aluPkg::sqrtStateE state;
    logic [aluPkg::SqrtCountWidth-1:0] stepCnt;
    logic [aluPkg::DataWidth-1:0] radicand;
    logic [aluPkg::SqrtSteps:0] rem; // Never exceeds twice the root
    logic [aluPkg::SqrtSteps-1:0] root;
    logic [aluPkg::SqrtSteps+2:0] remShift;
    logic [aluPkg::SqrtSteps+2:0] trial;
    logic [aluPkg::SqrtSteps+2:0] diff;
    logic fits;
    logic [aluPkg::SqrtSteps:0] remNext;
    logic [aluPkg::SqrtSteps-1:0] rootNext;

    // Bring down the next two radicand bits
    assign remShift = {rem, radicand[aluPkg::DataWidth-1 -: 2]};
    assign trial = {1'b0, root, 2'b01};
    assign diff = remShift - trial;
    assign fits = remShift >= trial;
    assign remNext = fits ? diff[aluPkg::SqrtSteps:0] : remShift[aluPkg::SqrtSteps:0];
    assign rootNext = {root[aluPkg::SqrtSteps-2:0], fits};

    always_ff @(posedge Clock) begin
        if (!i_rstN) begin
            state <= aluPkg::SqrtIdle;
            stepCnt <= '0;
            o_valid <= 1'b0;
        end else begin
            o_valid <= 1'b0;
            if (state == aluPkg::SqrtIdle && launch.goSqrt) begin
                state <= aluPkg::SqrtRun;
                stepCnt <= aluPkg::SqrtLast;
            end else if (state == aluPkg::SqrtRun) begin
                if (stepCnt == '0) begin
                    state <= aluPkg::SqrtIdle;
                    o_valid <= 1'b1;
                end else begin
                    stepCnt <= stepCnt - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (launch.goSqrt) begin
            radicand <= launch.opA;
            rem <= '0;
            root <= '0;
        end else if (state == aluPkg::SqrtRun) begin
            radicand <= radicand << 2;
            rem <= remNext;
            root <= rootNext;
            if (stepCnt == '0) begin
                o_result <= {{(aluPkg::DataWidth - aluPkg::SqrtSteps){1'b0}}, rootNext};
            end
        end
    end

    noGoWhileRun: assert property (@(posedge Clock) disable iff (!i_rstN)
        launch.goSqrt |-> state == aluPkg::SqrtIdle);

endmodule

/* source/aluCommit.sv */
`timescale 1ns/1ps

module aluCommit (
    input  logic                           Clock,
    input  logic                           i_rstN,
    aluLaunchIf.commit                     launch,
    input  logic                           i_simpleValid,
    input  logic [aluPkg::DataWidth-1:0]   i_simpleResult,
    input  logic                           i_divValid,
    input  logic [aluPkg::DataWidth-1:0]   i_divResult,
    input  logic                           i_sqrtValid,
    input  logic [aluPkg::DataWidth-1:0]   i_sqrtResult,
    output logic                           o_done,
    output logic [aluPkg::DataWidth-1:0]   o_result
);

    logic anyValid;
    logic anyGo;

    assign anyValid = i_simpleValid || i_divValid || i_sqrtValid;
    assign anyGo = launch.goSimple || launch.goDiv || launch.goSqrt;

    always_ff @(posedge Clock) begin
        if (!i_rstN) begin
            o_done <= 1'b1;
            o_result <= '0;
        end else if (anyValid) begin
            o_done <= 1'b1;
            if (i_simpleValid) o_result <= i_simpleResult;
            else if (i_divValid) o_result <= i_divResult;
            else o_result <= i_sqrtResult;
        end else if (anyGo) begin
            o_done <= 1'b0; // Running until a unit reports back
        end
    end

    // A unit may only finish an operation that was accepted
    validWhileBusy: assert property (@(posedge Clock) disable iff (!i_rstN)
        anyValid |-> !o_done && $onehot0({i_simpleValid, i_divValid, i_sqrtValid}));

endmodule

/* source/aluCore.sv */
`timescale 1ns/1ps

module aluCore (
    input  logic                           Clock,
    input  logic                           i_rstN,
    input  logic                           i_start,
    input  logic [aluPkg::FuncWidth-1:0]   i_func,
    input  logic [aluPkg::DataWidth-1:0]   i_opA,
    input  logic [aluPkg::DataWidth-1:0]   i_opB,
    output logic                           o_done,
    output logic [aluPkg::DataWidth-1:0]   o_result
);

    logic simpleValid;
    logic divValid;
    logic sqrtValid;
    logic [aluPkg::DataWidth-1:0] simpleResult;
    logic [aluPkg::DataWidth-1:0] divResult;
    logic [aluPkg::DataWidth-1:0] sqrtResult;

    aluLaunchIf launch ();

    aluDispatch u_dispatch (
        .Clock   (Clock),
        .i_rstN  (i_rstN),
        .i_start (i_start),
        .i_func  (i_func),
        .i_opA   (i_opA),
        .i_opB   (i_opB),
        .i_busy  (~o_done), // Done low means an operation is running
        .launch  (launch)
    );

    aluSimpleOps u_simpleOps (
        .Clock    (Clock),
        .i_rstN   (i_rstN),
        .launch   (launch),
        .o_valid  (simpleValid),
        .o_result (simpleResult)
    );

    aluDivider u_divider (
        .Clock    (Clock),
        .i_rstN   (i_rstN),
        .launch   (launch),
        .o_valid  (divValid),
        .o_result (divResult)
    );

    aluIntSqrt u_intSqrt (
        .Clock    (Clock),
        .i_rstN   (i_rstN),
        .launch   (launch),
        .o_valid  (sqrtValid),
        .o_result (sqrtResult)
    );

    aluCommit u_commit (
        .Clock          (Clock),
        .i_rstN         (i_rstN),
        .launch         (launch),
        .i_simpleValid  (simpleValid),
        .i_simpleResult (simpleResult),
        .i_divValid     (divValid),
        .i_divResult    (divResult),
        .i_sqrtValid    (sqrtValid),
        .i_sqrtResult   (sqrtResult),
        .o_done         (o_done),
        .o_result       (o_result)
    );

endmodule

/* tests/aluCoreTb.sv */
`timescale 1ns/1ps

module aluCoreTb;

    logic Clock;
    logic i_rstN;
    logic i_start;
    logic [aluPkg::FuncWidth-1:0] i_func;
    logic [aluPkg::DataWidth-1:0] i_opA;
    logic [aluPkg::DataWidth-1:0] i_opB;
    logic o_done;
    logic [aluPkg::DataWidth-1:0] o_result;

    logic [aluPkg::FuncWidth-1:0] simpleCodes [$];
    logic [aluPkg::DataWidth-1:0] edgeA [$];
    logic [aluPkg::DataWidth-1:0] edgeB [$];
    logic [aluPkg::DataWidth-1:0] divA [$];
    logic [aluPkg::DataWidth-1:0] divB [$];
    logic [aluPkg::DataWidth-1:0] sqrtIn [$];

    aluCore u_aluCore (
        .Clock    (Clock),
        .i_rstN   (i_rstN),
        .i_start  (i_start),
        .i_func   (i_func),
        .i_opA    (i_opA),
        .i_opB    (i_opB),
        .o_done   (o_done),
        .o_result (o_result)
    );

    initial begin
        Clock = 1'b0;
        forever #20 Clock = ~Clock;
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic checkValue(input string what, input logic [aluPkg::DataWidth-1:0] got,
                              input logic [aluPkg::DataWidth-1:0] exp);
        assert (got === exp)
            else abortRun($sformatf("ERR %0t: %s got %h, expected %h", $time, what, got, exp));
    endtask

    task automatic nextCycle();
        @(posedge Clock);
        #2; // Drive and sample just after the edge
    endtask

    task automatic waitDone(output int lowCycles);
        lowCycles = 0;
        while (!o_done) begin
            if (lowCycles >= 100) begin
                abortRun("o_done never returned high within 100 cycles");
            end
            nextCycle();
            lowCycles++;
        end
    endtask

    task automatic launchOp(input logic [aluPkg::FuncWidth-1:0] func,
                            input logic [aluPkg::DataWidth-1:0] a,
                            input logic [aluPkg::DataWidth-1:0] b,
                            output logic [aluPkg::DataWidth-1:0] res, output int lowCycles);
        int idleWait;
        waitDone(idleWait);
        i_start = 1'b1;
        i_func = func;
        i_opA = a;
        i_opB = b;
        nextCycle();
        i_start = 1'b0;
        assert (!o_done) else abortRun("o_done stayed high after an accepted start");
        waitDone(lowCycles);
        res = o_result;
    endtask

    function automatic logic [aluPkg::DataWidth-1:0] simpleModel(
            input logic [aluPkg::FuncWidth-1:0] func,
            input logic [aluPkg::DataWidth-1:0] a, input logic [aluPkg::DataWidth-1:0] b);
        logic [4:0] s;
        logic [aluPkg::DataWidth-1:0] ones;
        logic [aluPkg::DataWidth-1:0] top;
        s = b[4:0];
        ones = '1;
        top = 32'h8000_0000; // Flipping the sign bit turns signed order into unsigned
        case (func)
            aluPkg::IntAdd:          return a + b;
            aluPkg::IntSub:          return a - b;
            aluPkg::IntMul:          return a * b;
            aluPkg::ShiftLeftArith,
            aluPkg::ShiftLeftLogic:  return a << s;
            aluPkg::ShiftRightLogic: return a >> s;
            aluPkg::ShiftRightArith: return (a >> s) | (a[31] ? ~(ones >> s) : 32'h0);
            aluPkg::CmpEq:           return (a == b) ? 1 : 0;
            aluPkg::CmpNe:           return (a != b) ? 1 : 0;
            aluPkg::CmpGt:           return ((a ^ top) > (b ^ top)) ? 1 : 0;
            aluPkg::CmpGe:           return ((a ^ top) >= (b ^ top)) ? 1 : 0;
            aluPkg::LogNot:          return ~a;
            aluPkg::LogAnd:          return a & b;
            aluPkg::LogOr:           return a | b;
            aluPkg::LogXor:          return a ^ b;
            aluPkg::LogXnor:         return ~(a ^ b);
            default:                 return 32'h0;
        endcase
    endfunction

    // Truncating divide built from magnitudes
    function automatic logic [aluPkg::DataWidth-1:0] divModel(input logic isMod,
            input logic [aluPkg::DataWidth-1:0] a, input logic [aluPkg::DataWidth-1:0] b);
        logic [aluPkg::DataWidth-1:0] magA;
        logic [aluPkg::DataWidth-1:0] magB;
        logic [aluPkg::DataWidth-1:0] q;
        logic [aluPkg::DataWidth-1:0] r;
        if (b == 32'h0) begin
            if (isMod) return a;
            return 32'hFFFF_FFFF;
        end
        magA = a[31] ? -a : a;
        magB = b[31] ? -b : b;
        q = magA / magB;
        r = magA % magB;
        if (isMod) return a[31] ? -r : r;
        return (a[31] ^ b[31]) ? -q : q;
    endfunction

    function automatic logic [aluPkg::DataWidth-1:0] sqrtModel(
            input logic [aluPkg::DataWidth-1:0] x);
        logic [63:0] r;
        logic [63:0] t;
        r = 64'd0;
        for (int i = 15; i >= 0; i--) begin
            t = r | (64'd1 << i);
            if (t * t <= {32'd0, x}) r = t;
        end
        return r[31:0];
    endfunction

    function automatic logic [aluPkg::DataWidth-1:0] modelFor(
            input logic [aluPkg::FuncWidth-1:0] func,
            input logic [aluPkg::DataWidth-1:0] a, input logic [aluPkg::DataWidth-1:0] b);
        if (func == aluPkg::IntDiv) return divModel(1'b0, a, b);
        if (func == aluPkg::IntMod) return divModel(1'b1, a, b);
        if (func == aluPkg::IntSqrt) return sqrtModel(a);
        return simpleModel(func, a, b);
    endfunction

    task automatic checkRoot(input logic [aluPkg::DataWidth-1:0] x,
                             input logic [aluPkg::DataWidth-1:0] r);
        logic [63:0] r64;
        r64 = {32'd0, r};
        assert (r64 * r64 <= {32'd0, x} && {32'd0, x} < (r64 + 1) * (r64 + 1))
            else abortRun($sformatf("ERR %0t: square root of %h gave %h", $time, x, r));
    endtask

    // Result only moves when an operation completes
    resultHeld: assert property (@(posedge Clock) disable iff (!i_rstN)
        $past(o_done) |-> $stable(o_result))
        else abortRun("o_result changed while no operation was completing");

    doneFallsOnStart: assert property (@(posedge Clock) disable iff (!i_rstN)
        $fell(o_done) |-> $past(i_start))
        else abortRun("o_done went low without a start");

    initial begin
        logic [aluPkg::DataWidth-1:0] res;
        logic [aluPkg::DataWidth-1:0] a;
        logic [aluPkg::DataWidth-1:0] b;
        logic [aluPkg::FuncWidth-1:0] code;
        int lowCycles;
        int sel;
        i_rstN = 1'b0;
        i_start = 1'b0;
        i_func = '0;
        i_opA = '0;
        i_opB = '0;
        void'($urandom(32'h79eff058));
        simpleCodes = '{aluPkg::IntAdd, aluPkg::IntSub, aluPkg::IntMul, aluPkg::ShiftLeftArith,
                        aluPkg::ShiftRightArith, aluPkg::CmpEq, aluPkg::CmpNe, aluPkg::CmpGt,
                        aluPkg::CmpGe, aluPkg::LogNot, aluPkg::LogAnd, aluPkg::LogOr,
                        aluPkg::LogXor, aluPkg::LogXnor, aluPkg::ShiftLeftLogic,
                        aluPkg::ShiftRightLogic, 6'b111111}; // Last one is unknown
        edgeA = '{32'h0, 32'hFFFF_FFFF, 32'h8000_0000, 32'h8000_0000, 32'h1234_5678, 32'h8765_4321};
        edgeB = '{32'h0, 32'hFFFF_FFFF, 32'h1, 32'hFFFF_FFFF, 32'h0, 32'd31};
        divA = '{100, -100, 100, -100, 123, -123, 32'h8000_0000};
        divB = '{7, 7, -7, -7, 0, 0, -1};
        sqrtIn = '{32'h0, 32'h1, 32'd4, 32'd144, 32'd65536, 32'hFFFE_0001, 32'hFFFF_FFFF};

        repeat (8) nextCycle();
        i_rstN = 1'b1;
        checkValue("done after reset", {31'd0, o_done}, 32'd1);
        checkValue("result after reset", o_result, 32'h0);

        for (int c = 0; c < simpleCodes.size(); c++) begin
            for (int k = 0; k < edgeA.size() + 4; k++) begin
                a = (k < edgeA.size()) ? edgeA[k] : $urandom;
                b = (k < edgeB.size()) ? edgeB[k] : $urandom;
                launchOp(simpleCodes[c], a, b, res, lowCycles);
                checkValue($sformatf("func %b", simpleCodes[c]), res,
                           simpleModel(simpleCodes[c], a, b));
                checkValue("simple done-low cycles", lowCycles, 32'd1);
            end
        end

        for (int m = 0; m < 2; m++) begin
            code = (m == 0) ? aluPkg::IntDiv : aluPkg::IntMod;
            for (int k = 0; k < divA.size() + 8; k++) begin
                a = (k < divA.size()) ? divA[k] : $urandom;
                b = (k < divB.size()) ? divB[k] : ($urandom >> ($urandom % 32));
                launchOp(code, a, b, res, lowCycles);
                checkValue($sformatf("func %b of %h by %h", code, a, b), res, modelFor(code, a, b));
            end
        end

        for (int k = 0; k < sqrtIn.size() + 8; k++) begin
            a = (k < sqrtIn.size()) ? sqrtIn[k] : $urandom;
            launchOp(aluPkg::IntSqrt, a, 32'h0, res, lowCycles);
            checkRoot(a, res);
        end

        // Divide with dropped starts in flight
        a = $urandom;
        b = ($urandom % 1000) + 1;
        waitDone(lowCycles);
        i_start = 1'b1;
        i_func = aluPkg::IntDiv;
        i_opA = a;
        i_opB = b;
        nextCycle();
        i_start = 1'b0;
        repeat (3) nextCycle();
        i_start = 1'b1;
        i_func = aluPkg::IntAdd;
        nextCycle();
        i_func = aluPkg::IntSqrt;
        nextCycle();
        i_start = 1'b0;
        waitDone(lowCycles);
        checkValue("divide under busy starts", o_result, divModel(1'b0, a, b));
        repeat (40) begin
            nextCycle();
            assert (o_done) else abortRun("a second completion followed the divide");
        end

        for (int n = 0; n < 40; n++) begin
            sel = $urandom % 4;
            case (sel)
                0: code = simpleCodes[$urandom % simpleCodes.size()];
                1: code = aluPkg::IntDiv;
                2: code = aluPkg::IntMod;
                default: code = aluPkg::IntSqrt;
            endcase
            a = $urandom;
            b = $urandom >> ($urandom % 32);
            launchOp(code, a, b, res, lowCycles);
            checkValue($sformatf("mixed op %0d func %b", n, code), res, modelFor(code, a, b));
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* aluCore.f */
source/aluPkg.sv
source/aluLaunchIf.sv
source/aluDispatch.sv
source/aluSimpleOps.sv
source/aluDivider.sv
source/aluIntSqrt.sv
source/aluCommit.sv
source/aluCore.sv
tests/aluCoreTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module aluCoreTb -f aluCore.f -o aluCoreSim

# A fatal stop exits nonzero, the grep below makes the call
out=$(./obj_dir/aluCoreSim 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi
exit 1
